/* compile.f */
+incdir+src
src/trace_pkg.sv
src/tick_gen.sv
src/button_conditioner.sv
src/press_arbiter.sv
src/segment_tracer.sv
src/trace_top.sv
bench/tb_clock.sv
bench/trace_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module trace_tb \
    -o trace_sim > build.log 2>&1 \
    && ./obj_dir/trace_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^Result: PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "pass line not found in sim.log"; exit 1; }

/* bench/trace_tb.sv */
`timescale 1ns/1ps
`include "trace_defines.svh"

module trace_tb;

    localparam int hold_len  = (`TRACE_DEBOUNCE_LEN + 2) * `TRACE_SAMPLE_DIV;
    localparam int short_len = (`TRACE_DEBOUNCE_LEN - 1) * `TRACE_SAMPLE_DIV;

    // Per test, in seconds: reset, start, moving, walk, illegal, completion
    localparam int budget_cycles = (1 + 5 + 6 + 14 + 7 + 4) * `TRACE_SECOND_DIV;

    // Active low, bit 0 is segment A
    localparam trace_pkg::seg_vec_t g_only = 7'b0111111;
    localparam trace_pkg::seg_vec_t a_only = 7'b1111110;
    localparam trace_pkg::seg_vec_t b_only = 7'b1111101;
    localparam trace_pkg::seg_vec_t c_only = 7'b1111011;

    localparam trace_pkg::seg_idx_t sa = trace_pkg::seg_a;
    localparam trace_pkg::seg_idx_t sb = trace_pkg::seg_b;
    localparam trace_pkg::seg_idx_t sc = trace_pkg::seg_c;
    localparam trace_pkg::seg_idx_t sd = trace_pkg::seg_d;
    localparam trace_pkg::seg_idx_t se = trace_pkg::seg_e;
    localparam trace_pkg::seg_idx_t sf = trace_pkg::seg_f;
    localparam trace_pkg::seg_idx_t sg = trace_pkg::seg_g;
    localparam trace_pkg::dir_t     hr = trace_pkg::dir_right;
    localparam trace_pkg::dir_t     hl = trace_pkg::dir_left;
    localparam trace_pkg::dir_t     hu = trace_pkg::dir_up;
    localparam trace_pkg::dir_t     hd = trace_pkg::dir_down;

    // {segment, heading, button, new segment, new heading}
    localparam logic [11:0] step_tab [19] = '{
        {sa, hr, hr, sb, hd}, {sa, hl, hl, sf, hd},
        {sb, hu, hl, sa, hl}, {sb, hd, hr, sg, hl}, {sb, hd, hu, sc, hd},
        {sc, hu, hl, sg, hl}, {sc, hu, hu, sb, hu}, {sc, hd, hr, sd, hd},
        {sd, hr, hl, sc, hu}, {sd, hl, hr, se, hu},
        {se, hu, hr, sg, hr}, {se, hu, hu, sf, hu}, {se, hd, hl, sd, hr},
        {sf, hu, hr, sa, hr}, {sf, hd, hl, sg, hr},
        {sg, hr, hl, sb, hu}, {sg, hr, hr, sc, hd}, {sg, hl, hl, se, hd}, {sg, hl, hr, sf, hu}
    };

    logic       clk;
    logic       rst;
    logic       right;
    logic       left;
    logic       up;
    logic       down;
    logic [6:0] seg;
    logic       init;
    logic       move;
    logic       fall;
    logic [1:0] pos;

    int                  cycles;
    int                  errors;
    int                  checks;
    trace_pkg::seg_idx_t cur_seg;
    trace_pkg::dir_t     cur_head;
    trace_pkg::seg_vec_t visited;

    tb_clock #(.half_period(10), .reset_cycles(3)) i_clock (.clk(clk), .rst(rst));

    trace_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .right (right),
        .left  (left),
        .up    (up),
        .down  (down),
        .seg   (seg),
        .init  (init),
        .move  (move),
        .fall  (fall),
        .pos   (pos)
    );

    // Edges since reset release, same origin as the tick counters
    always @(posedge clk) begin
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic check_seg(input string name, input trace_pkg::seg_vec_t exp,
                             input trace_pkg::seg_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: seg expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_dir(input string name, input trace_pkg::dir_t exp,
                             input trace_pkg::dir_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: pos expected %0d actual %0d", name, exp, act);
        end
    endtask

    // Flags as {init, move, fall}
    task automatic check_state(input string name, input logic [2:0] exp);
        checks++;
        if ({init, move, fall} !== exp) begin
            errors++;
            $display("error %s: flags expected %b actual %b", name, exp, {init, move, fall});
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("error %s: cycle expected %0d actual %0d", name, exp, act);
        end
    endtask

    function automatic logic [4:0] table_lookup(input trace_pkg::seg_idx_t s,
                                                input trace_pkg::dir_t h,
                                                input trace_pkg::dir_t b);
        logic [4:0] res;
        res = {s, h};
        for (int k = 0; k < 19; k++) begin
            if (step_tab[k][11:5] == {s, h, b}) begin
                res = step_tab[k][4:0];
            end
        end
        return res;
    endfunction

    task automatic drive_button(input trace_pkg::dir_t b, input logic level);
        case (b)
            trace_pkg::dir_right: right = level;
            trace_pkg::dir_left:  left  = level;
            trace_pkg::dir_up:    up    = level;
            default:              down  = level;
        endcase
    endtask

    task automatic press_button(input trace_pkg::dir_t b, input int hold);
        int gap;
        gap = $urandom % (2 * `TRACE_SAMPLE_DIV + 1);
        drive_button(b, 1'b1);
        repeat (hold) @(negedge clk);
        drive_button(b, 1'b0);
        repeat (hold_len + gap) @(negedge clk);
    endtask

    // Visited set outside the cursor, then both blink phases on the cursor
    task automatic check_trace(input string name);
        trace_pkg::seg_vec_t mask;
        trace_pkg::seg_vec_t masked;
        logic                seen_lit;
        logic                seen_dark;
        logic                bad;
        mask = '0;
        mask[cur_seg] = 1'b1;
        seen_lit = 1'b0;
        seen_dark = 1'b0;
        bad = 1'b0;
        for (int i = 0; i < 2 * `TRACE_BLINK_DIV + 2; i++) begin
            @(negedge clk);
            masked = seg | mask;
            if (!bad && (i == 0 || masked != (visited | mask))) begin
                check_seg(name, visited | mask, masked);
                bad = (masked != (visited | mask));
            end
            if (seg[cur_seg]) begin
                seen_dark = 1'b1;
            end else begin
                seen_lit = 1'b1;
            end
        end
        if (!(seen_lit && seen_dark)) begin
            errors++;
            $display("%s: cursor segment %0d did not blink", name, cur_seg);
        end
    endtask

    task automatic step(input string name, input trace_pkg::dir_t b);
        logic [4:0] nxt;
        press_button(b, hold_len);
        nxt = table_lookup(cur_seg, cur_head, b);
        cur_seg = trace_pkg::seg_idx_t'(nxt[4:2]);
        cur_head = trace_pkg::dir_t'(nxt[1:0]);
        visited[cur_seg] = 1'b0;
        check_state(name, 3'b001);
        check_dir(name, cur_head, trace_pkg::dir_t'(pos));
        check_trace(name);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_state("reset_state", 3'b100);
        check_seg("reset_state", g_only, seg);
        check_dir("reset_state", trace_pkg::dir_left, trace_pkg::dir_t'(pos));
    endtask

    task automatic test_start_duration();
        int   rise;
        logic bad;
        rise = -1;
        bad = 1'b0;
        wait (!rst);
        while (rise < 0 && cycles < 4 * `TRACE_SECOND_DIV) begin
            @(negedge clk);
            // A press here must be swallowed
            if (cycles == `TRACE_SECOND_DIV) begin
                right = 1'b1;
            end
            if (cycles == `TRACE_SECOND_DIV + hold_len) begin
                right = 1'b0;
            end
            if (move) begin
                rise = cycles;
            end else if (!bad && (seg != g_only || !init)) begin
                check_seg("start_duration", g_only, seg);
                check_state("start_duration", 3'b100);
                bad = 1'b1;
            end
        end
        check_count("start_duration", 3 * `TRACE_SECOND_DIV + 1, rise);
    endtask

    task automatic test_moving_display();
        check_state("moving_display", 3'b010);
        check_seg("moving_display", g_only, seg);
        press_button(trace_pkg::dir_right, hold_len);
        check_seg("moving_right", a_only, seg);
        press_button(trace_pkg::dir_left, hold_len);
        check_seg("moving_left", b_only, seg);
        press_button(trace_pkg::dir_up, hold_len);
        check_seg("moving_up", c_only, seg);
        // Too short to debounce, would start tracing otherwise
        press_button(trace_pkg::dir_down, short_len);
        check_seg("moving_short", c_only, seg);
        check_state("moving_short", 3'b010);
    endtask

    task automatic test_trace_walk();
        press_button(trace_pkg::dir_down, hold_len);
        cur_seg = trace_pkg::seg_g;
        cur_head = trace_pkg::dir_left;
        visited = '1;
        visited[cur_seg] = 1'b0;
        check_state("trace_enter", 3'b001);
        check_dir("trace_enter", cur_head, trace_pkg::dir_t'(pos));
        check_trace("trace_enter");
        // Last left of the walk is left to the completion test
        step("trace_walk_1", trace_pkg::dir_left);
        step("trace_walk_2", trace_pkg::dir_left);
        step("trace_walk_3", trace_pkg::dir_left);
        step("trace_walk_4", trace_pkg::dir_up);
        step("trace_walk_5", trace_pkg::dir_left);
    endtask

    task automatic test_illegal_moves();
        step("illegal_right", trace_pkg::dir_right);
        step("illegal_up", trace_pkg::dir_up);
        step("illegal_down", trace_pkg::dir_down);
    endtask

    task automatic test_completion();
        logic [4:0] nxt;
        int         done_at;
        int         init_at;
        logic       bad;
        nxt = table_lookup(cur_seg, cur_head, trace_pkg::dir_left);
        done_at = -1;
        init_at = -1;
        bad = 1'b0;
        // Up loses to left, then waits behind the full ring
        left = 1'b1;
        up = 1'b1;
        for (int n = 0; n < 4 * hold_len && init_at < 0; n++) begin
            @(negedge clk);
            if (n == hold_len) begin
                left = 1'b0;
                up = 1'b0;
            end
            if (done_at < 0 && pos == nxt[1:0]) begin
                done_at = cycles;
            end
            if (init) begin
                init_at = cycles;
            end
        end
        left = 1'b0;
        up = 1'b0;
        if (done_at < 0 || init_at < 0) begin
            errors++;
            $display("completion: the last step or the return to start never happened");
        end else begin
            check_count("completion", done_at + 1 +
                        (`TRACE_HALF_DIV - done_at % `TRACE_HALF_DIV) % `TRACE_HALF_DIV,
                        init_at);
        end
        repeat (2 * hold_len) begin
            @(negedge clk);
            if (!bad && (seg != g_only || {init, move, fall} != 3'b100)) begin
                check_seg("completion_hold", g_only, seg);
                check_state("completion_hold", 3'b100);
                bad = 1'b1;
            end
        end
        check_seg("completion", g_only, seg);
        check_state("completion", 3'b100);
        check_dir("completion", trace_pkg::dir_left, trace_pkg::dir_t'(pos));
    endtask

    initial begin
        repeat (budget_cycles) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", budget_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        right = 1'b0;
        left = 1'b0;
        up = 1'b0;
        down = 1'b0;
        errors = 0;
        checks = 0;
        void'($urandom(73566));
        test_reset_state();
        test_start_duration();
        test_moving_display();
        test_trace_walk();
        test_illegal_moves();
        test_completion();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* src/trace_top.sv */
`timescale 1ns/1ps

module trace_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       right,
    input  logic       left,
    input  logic       up,
    input  logic       down,
    output logic [6:0] seg,
    output logic       init,
    output logic       move,
    output logic       fall,
    output logic [1:0] pos
);

    logic            sample_tick;
    logic            blink_tick;
    logic            half_tick;
    logic            second_tick;
    logic [3:0]      btn_vec;
    logic [3:0]      press_valid;
    logic [3:0]      press_ready;
    logic            cmd_valid;
    logic            cmd_ready;
    trace_pkg::dir_t cmd_dir;

    // Bit order matches the dir_t encoding
    assign btn_vec = {down, up, left, right};

    tick_gen i_tick_gen (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .blink_tick  (blink_tick),
        .half_tick   (half_tick),
        .second_tick (second_tick)
    );

    genvar n;
    generate
        for (n = 0; n < 4; n++) begin : g_btn
            button_conditioner i_cond (
                .clk         (clk),
                .rst         (rst),
                .sample_tick (sample_tick),
                .btn         (btn_vec[n]),
                .press_valid (press_valid[n]),
                .press_ready (press_ready[n])
            );
        end
    endgenerate

    press_arbiter i_arbiter (
        .clk         (clk),
        .rst         (rst),
        .press_valid (press_valid),
        .press_ready (press_ready),
        .cmd_valid   (cmd_valid),
        .cmd_dir     (cmd_dir),
        .cmd_ready   (cmd_ready)
    );

    segment_tracer i_tracer (
        .clk         (clk),
        .rst         (rst),
        .blink_tick  (blink_tick),
        .half_tick   (half_tick),
        .second_tick (second_tick),
        .cmd_valid   (cmd_valid),
        .cmd_dir     (cmd_dir),
        .cmd_ready   (cmd_ready),
        .seg         (seg),
        .init        (init),
        .move        (move),
        .fall        (fall),
        .pos         (pos)
    );

endmodule

/* src/segment_tracer.sv */
`timescale 1ns/1ps

module segment_tracer (
    input  logic                clk,
    input  logic                rst,
    input  logic                blink_tick,
    input  logic                half_tick,
    input  logic                second_tick,
    input  logic                cmd_valid,
    input  trace_pkg::dir_t     cmd_dir,
    output logic                cmd_ready,
    output trace_pkg::seg_vec_t seg,
    output logic                init,
    output logic                move,
    output logic                fall,
    output trace_pkg::dir_t     pos
);

    // Short names for the heading table
    localparam trace_pkg::dir_t d_right = trace_pkg::dir_right;
    localparam trace_pkg::dir_t d_left  = trace_pkg::dir_left;
    localparam trace_pkg::dir_t d_up    = trace_pkg::dir_up;
    localparam trace_pkg::dir_t d_down  = trace_pkg::dir_down;

    localparam trace_pkg::seg_idx_t s_a = trace_pkg::seg_a;
    localparam trace_pkg::seg_idx_t s_b = trace_pkg::seg_b;
    localparam trace_pkg::seg_idx_t s_c = trace_pkg::seg_c;
    localparam trace_pkg::seg_idx_t s_d = trace_pkg::seg_d;
    localparam trace_pkg::seg_idx_t s_e = trace_pkg::seg_e;
    localparam trace_pkg::seg_idx_t s_f = trace_pkg::seg_f;
    localparam trace_pkg::seg_idx_t s_g = trace_pkg::seg_g;

    trace_pkg::game_state_t state;
    trace_pkg::seg_idx_t    cursor;
    trace_pkg::dir_t        heading;
    trace_pkg::seg_vec_t    record;
    trace_pkg::seg_vec_t    move_seg;
    trace_pkg::seg_vec_t    trace_seg;
    logic [1:0]             sec_cnt;
    logic                   blink_phase;
    logic                   accept;
    logic                   all_visited;
    logic [4:0]             step_next;

    // Record is active low, so all zero means every segment seen
    assign all_visited = (record == '0);
    assign cmd_ready   = !(state == trace_pkg::st_tracing && all_visited);
    assign accept      = cmd_valid && cmd_ready;

    // Next {segment, heading} for the cursor, misses leave it in place
    always_comb begin
        case ({cursor, heading, cmd_dir})
            {s_a, d_right, d_right}: step_next = {s_b, d_down};
            {s_a, d_left,  d_left }: step_next = {s_f, d_down};
            {s_b, d_up,    d_left }: step_next = {s_a, d_left};
            {s_b, d_down,  d_right}: step_next = {s_g, d_left};
            {s_b, d_down,  d_up   }: step_next = {s_c, d_down};
            {s_c, d_up,    d_left }: step_next = {s_g, d_left};
            {s_c, d_up,    d_up   }: step_next = {s_b, d_up};
            {s_c, d_down,  d_right}: step_next = {s_d, d_down};
            {s_d, d_right, d_left }: step_next = {s_c, d_up};
            {s_d, d_left,  d_right}: step_next = {s_e, d_up};
            {s_e, d_up,    d_right}: step_next = {s_g, d_right};
            {s_e, d_up,    d_up   }: step_next = {s_f, d_up};
            {s_e, d_down,  d_left }: step_next = {s_d, d_right};
            {s_f, d_up,    d_right}: step_next = {s_a, d_right};
            {s_f, d_down,  d_left }: step_next = {s_g, d_right};
            {s_g, d_right, d_left }: step_next = {s_b, d_up};
            {s_g, d_right, d_right}: step_next = {s_c, d_down};
            {s_g, d_left,  d_left }: step_next = {s_e, d_down};
            {s_g, d_left,  d_right}: step_next = {s_f, d_up};
            default: step_next = {cursor, heading};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= trace_pkg::st_start;
            sec_cnt     <= 2'd0;
            cursor      <= s_g;
            heading     <= d_left;
            record      <= '1;
            move_seg    <= trace_pkg::seg_only(s_g);
            blink_phase <= 1'b0;
        end else begin
            case (state)
                trace_pkg::st_start: begin
                    // Commands still drain here, they just do nothing
                    if (second_tick) begin
                        if (sec_cnt == 2'd2) begin
                            state    <= trace_pkg::st_moving;
                            sec_cnt  <= 2'd0;
                            move_seg <= trace_pkg::seg_only(s_g);
                        end else begin
                            sec_cnt <= sec_cnt + 2'd1;
                        end
                    end
                end
                trace_pkg::st_moving: begin
                    if (accept) begin
                        case (cmd_dir)
                            d_right: move_seg <= trace_pkg::seg_only(s_a);
                            d_left:  move_seg <= trace_pkg::seg_only(s_b);
                            d_up:    move_seg <= trace_pkg::seg_only(s_c);
                            default: begin
                                state   <= trace_pkg::st_tracing;
                                cursor  <= s_g;
                                heading <= d_left;
                                record  <= trace_pkg::seg_only(s_g);
                            end
                        endcase
                    end
                end
                default: begin
                    if (all_visited) begin
                        if (half_tick) begin
                            state   <= trace_pkg::st_start;
                            sec_cnt <= 2'd0;
                            heading <= d_left;
                        end
                    end else if (accept) begin
                        cursor  <= trace_pkg::seg_idx_t'(step_next[4:2]);
                        heading <= trace_pkg::dir_t'(step_next[1:0]);
                        record[step_next[4:2]] <= 1'b0;
                    end
                end
            endcase
            if (blink_tick) begin
                blink_phase <= ~blink_phase;
            end
        end
    end

    // Visited segments lit, cursor flips with the blink phase
    always_comb begin
        trace_seg = record;
        if (blink_phase) begin
            trace_seg[cursor] = ~record[cursor];
        end
    end

    always_comb begin
        case (state)
            trace_pkg::st_moving:  seg = move_seg;
            trace_pkg::st_tracing: seg = trace_seg;
            default:               seg = trace_pkg::seg_only(s_g);
        endcase
    end

    assign init = (state == trace_pkg::st_start);
    assign move = (state == trace_pkg::st_moving);
    assign fall = (state == trace_pkg::st_tracing);
    assign pos  = heading;

endmodule

/* src/press_arbiter.sv */
`timescale 1ns/1ps

module press_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic [3:0]      press_valid,
    output logic [3:0]      press_ready,
    output logic            cmd_valid,
    output trace_pkg::dir_t cmd_dir,
    input  logic            cmd_ready
);

    logic       load_en;
    logic [1:0] pick;
    logic [3:0] grant;

    // Register is free, or drains on this edge
    assign load_en = !cmd_valid || cmd_ready;

    // Fixed priority, right first and down last
    always_comb begin
        pick  = 2'd0;
        grant = 4'b0000;
        for (int n = 3; n >= 0; n--) begin
            if (press_valid[n]) begin
                pick  = 2'(n);
                grant = 4'b0001 << n;
            end
        end
    end

    // Winner is acknowledged in the cycle it is loaded
    assign press_ready = load_en ? grant : 4'b0000;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid <= 1'b0;
        end else if (load_en) begin
            cmd_valid <= |press_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && |press_valid) begin
            cmd_dir <= trace_pkg::dir_t'(pick);
        end
    end

endmodule

/* src/button_conditioner.sv */
`timescale 1ns/1ps
`include "trace_defines.svh"

module button_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic sample_tick,
    input  logic btn,
    output logic press_valid,
    input  logic press_ready
);

    localparam int cnt_w = (`TRACE_DEBOUNCE_LEN > 1) ? $clog2(`TRACE_DEBOUNCE_LEN) : 1;

    logic [1:0]       btn_sync;
    logic [cnt_w-1:0] high_cnt;
    logic             armed;
    logic             qualify;

    // Final high sample of a run, only once per press
    assign qualify = sample_tick && btn_sync[1] && armed &&
                     (high_cnt == cnt_w'(`TRACE_DEBOUNCE_LEN - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_sync <= 2'b00;
        end else begin
            btn_sync <= {btn_sync[0], btn};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            high_cnt    <= '0;
            armed       <= 1'b1;
            press_valid <= 1'b0;
        end else begin
            if (sample_tick) begin
                if (btn_sync[1]) begin
                    // Saturate so a long hold does not wrap
                    if (high_cnt != cnt_w'(`TRACE_DEBOUNCE_LEN - 1)) begin
                        high_cnt <= high_cnt + 1'b1;
                    end
                    if (qualify) begin
                        armed <= 1'b0;
                    end
                end else begin
                    high_cnt <= '0;
                    armed    <= 1'b1;
                end
            end
            // A new press merges into one still waiting
            if (qualify) begin
                press_valid <= 1'b1;
            end else if (press_ready) begin
                press_valid <= 1'b0;
            end
        end
    end

endmodule

/* src/tick_gen.sv */
`timescale 1ns/1ps
`include "trace_defines.svh"

module tick_gen (
    input  logic clk,
    input  logic rst,
    output logic sample_tick,
    output logic blink_tick,
    output logic half_tick,
    output logic second_tick
);

    // One divider per tick, same order as the outputs
    localparam int div_tab [4] = '{
        `TRACE_SAMPLE_DIV,
        `TRACE_BLINK_DIV,
        `TRACE_HALF_DIV,
        `TRACE_SECOND_DIV
    };

    logic [3:0] ticks;

    genvar i;
    generate
        for (i = 0; i < 4; i++) begin : g_div
            localparam int w = (div_tab[i] > 1) ? $clog2(div_tab[i]) : 1;

            logic [w-1:0] cnt;
            logic         tick_q;

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    cnt    <= '0;
                    tick_q <= 1'b0;
                end else begin
                    // Pulse lands on the edge where the count wraps
                    tick_q <= (cnt == w'(div_tab[i] - 1));
                    if (cnt == w'(div_tab[i] - 1)) begin
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            end

            assign ticks[i] = tick_q;
        end
    endgenerate

    assign sample_tick = ticks[0];
    assign blink_tick  = ticks[1];
    assign half_tick   = ticks[2];
    assign second_tick = ticks[3];

endmodule

/* src/trace_pkg.sv */
package trace_pkg;

    // Button or heading direction
    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_left  = 2'd1,
        dir_up    = 2'd2,
        dir_down  = 2'd3
    } dir_t;

    // Segment index, bit position in the display word
    typedef enum logic [2:0] {
        seg_a = 3'd0,
        seg_b = 3'd1,
        seg_c = 3'd2,
        seg_d = 3'd3,
        seg_e = 3'd4,
        seg_f = 3'd5,
        seg_g = 3'd6
    } seg_idx_t;

    typedef enum logic [1:0] {
        st_start   = 2'd0,
        st_moving  = 2'd1,
        st_tracing = 2'd2
    } game_state_t;

    // Active low, bit i drives segment i
    typedef logic [6:0] seg_vec_t;

    // Pattern with a single segment lit
    function automatic seg_vec_t seg_only(seg_idx_t idx);
        return ~(seg_vec_t'(1) << idx);
    endfunction

endpackage

/* src/trace_defines.svh */
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// Tick dividers, all in clk cycles
// Predefining TRACE_DEFINES_SVH skips this file, so a build can supply all five values itself

// Spacing of button samples
`define TRACE_SAMPLE_DIV 4

// Cursor blink toggle period
`define TRACE_BLINK_DIV 16

// Return delay after the last segment
`define TRACE_HALF_DIV 32

// Start phase timing
`define TRACE_SECOND_DIV 64

// Consecutive high samples that make a press
`define TRACE_DEBOUNCE_LEN 4

`endif
